// File: common/pe_consts.svh
`ifndef PE_CONSTS_SVH
`define PE_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// multiplier geometry
////////////////////////////////////////////////////////////////////////////

`define PE_MULT_A_W 25 // signed port a of the dsp multiplier
`define PE_MULT_B_W 18 // signed port b
`define PE_PROD_W   43 // full product width, a + b

////////////////////////////////////////////////////////////////////////////
// lane packing
////////////////////////////////////////////////////////////////////////////

`define PE_LANE88_W 24 // 8x8 accumulator, 16 bit product plus 8 headroom
`define PE_LANE18_W 16 // 1x8 accumulator, 9 bit product plus headroom
`define PE_FIELD88  16 // product field spacing in 8x8 mode
`define PE_FIELD18  9  // product field spacing in 1x8 mode

// operand reg + product reg
`define PE_MULT_LAT 2

// longest job, sized against the 1x8 lane headroom
`define PE_MAX_BEATS 64

`endif

// File: common/pe_pkg.sv
`include "pe_consts.svh"

////////////////////////////////////////////////////////////////////////////
// types shared by the pe row
////////////////////////////////////////////////////////////////////////////

package pe_pkg;

  // packing mode of a job
  typedef enum logic {
    MODE_88 = 1'b0, // two pixels x one 8 bit weight
    MODE_18 = 1'b1  // two pixels x two binary weights
  } pe_mode_e;

  // controller states
  typedef enum logic [1:0] {
    IDLE  = 2'd0, // waiting for first beat
    RUN   = 2'd1, // job streaming
    DRAIN = 2'd2, // last beat in, multiplier emptying
    HOLD  = 2'd3  // result presented
  } ctrl_state_e;

  // one input beat
  typedef struct packed {
    pe_mode_e           mode;
    logic signed [7:0]  pixel0;
    logic signed [7:0]  pixel1;
    logic signed [7:0]  weight0; // bit 0 is the binary weight in 1x8
    logic               weight1; // 1x8 only
    logic               last;    // closes the job
  } pe_beat_t;

  // multiplier operands
  typedef struct packed {
    logic signed [`PE_MULT_A_W-1:0] op_a;
    logic signed [`PE_MULT_B_W-1:0] op_b;
  } mult_ops_t;

  // job result
  // 1x8 lanes are 16 bit sums sign extended to 24
  // 8x8 leaves lane2/lane3 at zero
  typedef struct packed {
    pe_mode_e                       mode;
    logic signed [`PE_LANE88_W-1:0] lane0;
    logic signed [`PE_LANE88_W-1:0] lane1;
    logic signed [`PE_LANE88_W-1:0] lane2;
    logic signed [`PE_LANE88_W-1:0] lane3;
  } pe_result_t;

endpackage

// File: pe_row/pe_row_ctrl.sv
`timescale 1ns/100ps
`include "pe_consts.svh"

module pe_row_ctrl
  import pe_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  input  logic     in_last,
  input  pe_mode_e in_mode,
  output logic     in_ready,
  output logic     mult_en,
  output logic     acc_en,
  output logic     acc_clear,
  output pe_mode_e acc_mode,
  output logic     out_valid,
  input  logic     out_ready
);

  ctrl_state_e state, state_nxt;

  logic in_fire;   // beat transfer this cycle
  logic job_start; // first beat of a job

  // bit 0 set with the operand reg, bit 1 with the product reg,
  // bit 2 once that product has landed in the lanes
  logic [`PE_MULT_LAT:0]   vld_pipe;
  logic [`PE_MULT_LAT-1:0] first_pipe; // marks the job's first product

  pe_mode_e job_mode;

  ////////////////////////////////////////////////////////////////////////////
  // handshake decode
  ////////////////////////////////////////////////////////////////////////////

  assign in_ready  = (state == IDLE) || (state == RUN); // closed from last beat on
  assign in_fire   = in_valid && in_ready;
  assign job_start = in_fire && (state == IDLE);
  assign out_valid = (state == HOLD);

  ////////////////////////////////////////////////////////////////////////////
  // fsm
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (in_fire) state_nxt = in_last ? DRAIN : RUN; // single beat job skips RUN
      end
      RUN: begin
        if (in_fire && in_last) state_nxt = DRAIN;
      end
      DRAIN: begin
        // last product just written and nothing behind it
        if (vld_pipe == {1'b1, {`PE_MULT_LAT{1'b0}}}) state_nxt = HOLD;
      end
      HOLD: begin
        if (out_ready) state_nxt = IDLE;
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      vld_pipe   <= '0;
      first_pipe <= '0;
      job_mode   <= MODE_88;
    end else begin
      state      <= state_nxt;
      vld_pipe   <= {vld_pipe[`PE_MULT_LAT-1:0], in_fire};   // rides with the mult
      first_pipe <= {first_pipe[`PE_MULT_LAT-2:0], job_start};
      if (job_start) job_mode <= in_mode; // mode latched per job
    end
  end

  // advance on a new beat or while the operand stage holds one
  assign mult_en   = in_fire || (|vld_pipe[`PE_MULT_LAT-2:0]);
  assign acc_en    = vld_pipe[`PE_MULT_LAT-1];   // product reg valid
  assign acc_clear = first_pipe[`PE_MULT_LAT-1]; // load instead of add
  assign acc_mode  = job_mode;

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // result presented until taken
  a_out_hold : assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid);

  // result three cycles after the last beat, input closed while it waits
  a_result_latency : assert property (@(posedge clk) disable iff (reset)
    in_fire && in_last |=> !out_valid ##1 !out_valid ##1 !out_valid
                           ##1 (out_valid && !in_ready));

endmodule

// File: pe_row/operand_packer.sv
`timescale 1ns/100ps
`include "pe_consts.svh"

module operand_packer
  import pe_pkg::*;
(
  input  pe_beat_t  beat,
  output mult_ops_t ops
);

  // pixels sign extended to either port
  logic signed [`PE_MULT_A_W-1:0] px0_a;
  logic signed [`PE_MULT_A_W-1:0] px1_a;
  logic signed [`PE_MULT_B_W-1:0] px0_b;
  logic signed [`PE_MULT_B_W-1:0] px1_b;
  logic signed [`PE_MULT_B_W-1:0] wt_b;   // 8 bit weight on port b
  logic        [`PE_MULT_A_W-1:0] wbin_a; // binary weights on port a

  always_comb begin
    px0_a = beat.pixel0;
    px1_a = beat.pixel1;
    px0_b = beat.pixel0;
    px1_b = beat.pixel1;
    wt_b  = beat.weight0;

    // w0 at bit 0, w1 at bit 18 (two 1x8 fields up)
    wbin_a                    = '0;
    wbin_a[0]                 = beat.weight0[0];
    wbin_a[2 * `PE_FIELD18]   = beat.weight1;

    if (beat.mode == MODE_88) begin
      // p0 + p1*2^16 times w, fields at 0 and 16
      ops.op_a = px0_a + (px1_a <<< `PE_FIELD88);
      ops.op_b = wt_b;
    end else begin
      // w0 + w1*2^18 times p0 + p1*2^9
      // p0w0 @0, p1w0 @9, p0w1 @18, p1w1 @27
      ops.op_a = wbin_a;
      ops.op_b = px0_b + (px1_b <<< `PE_FIELD18);
    end
  end

endmodule

// File: pe_row/packed_mult.sv
`timescale 1ns/100ps
`include "pe_consts.svh"

////////////////////////////////////////////////////////////////////////////
// behavioral stand-in for a 25x18 dsp slice
// areg then preg, both on the same clock enable
////////////////////////////////////////////////////////////////////////////

module packed_mult
  import pe_pkg::*;
(
  input  logic                         clk,
  input  logic                         en,
  input  mult_ops_t                    ops,
  output logic signed [`PE_PROD_W-1:0] prod
);

  mult_ops_t ops_q; // operand stage

  always_ff @(posedge clk) begin
    if (en) begin
      ops_q <= ops;
      prod  <= ops_q.op_a * ops_q.op_b; // signed, full 43 bit
    end
  end

endmodule

// File: pe_row/lane_accumulator.sv
`timescale 1ns/100ps
`include "pe_consts.svh"

module lane_accumulator
  import pe_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         en,
  input  logic                         clear,
  input  pe_mode_e                     mode,
  input  logic signed [`PE_PROD_W-1:0] prod,
  output pe_result_t                   result
);

  // 8x8 fields, 24 bit
  logic signed [`PE_LANE88_W-1:0] f0_88;
  logic signed [`PE_LANE88_W-1:0] f1_88;

  // 1x8 fields, 16 bit
  logic signed [`PE_LANE18_W-1:0] f0_18;
  logic signed [`PE_LANE18_W-1:0] f1_18;
  logic signed [`PE_LANE18_W-1:0] f2_18;
  logic signed [`PE_LANE18_W-1:0] f3_18;

  // running sums, zero on the first product of a job
  logic signed [`PE_LANE88_W-1:0] base0;
  logic signed [`PE_LANE88_W-1:0] base1;
  logic signed [`PE_LANE88_W-1:0] base2;
  logic signed [`PE_LANE88_W-1:0] base3;

  // 16 bit wrap, result sign extended back to lane width
  function automatic logic signed [`PE_LANE88_W-1:0] add_lane18(
    input logic signed [`PE_LANE88_W-1:0] acc,
    input logic signed [`PE_LANE18_W-1:0] field
  );
    logic signed [`PE_LANE18_W-1:0] sum;
    sum = acc[`PE_LANE18_W-1:0] + field;
    return sum;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // field slicing with borrow correction
  ////////////////////////////////////////////////////////////////////////////

  // a negative lower field borrows one from the field above it,
  // so its sign bit is added back

  always_comb begin
    f0_88 = $signed(prod[`PE_FIELD88-1:0]);
    f1_88 = $signed(prod[`PE_FIELD88 +: `PE_FIELD88])
          + $signed({1'b0, prod[`PE_FIELD88-1]});

    f0_18 = $signed(prod[0 +: `PE_FIELD18]);
    f1_18 = $signed(prod[`PE_FIELD18 +: `PE_FIELD18])
          + $signed({1'b0, prod[`PE_FIELD18-1]});     // p1w0 + sign of p0w0
    f2_18 = $signed(prod[2*`PE_FIELD18 +: `PE_FIELD18])
          + $signed({1'b0, prod[2*`PE_FIELD18-1]});   // sign of bits 17:0
    f3_18 = $signed(prod[3*`PE_FIELD18 +: `PE_FIELD18])
          + $signed({1'b0, prod[3*`PE_FIELD18-1]});   // sign of bits 26:0
  end

  assign base0 = clear ? '0 : result.lane0;
  assign base1 = clear ? '0 : result.lane1;
  assign base2 = clear ? '0 : result.lane2;
  assign base3 = clear ? '0 : result.lane3;

  ////////////////////////////////////////////////////////////////////////////
  // lane registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0; // mode back to 8x8, lanes zero
    end else if (en) begin
      result.mode <= mode;
      if (mode == MODE_88) begin
        result.lane0 <= base0 + f0_88; // wraps at 24
        result.lane1 <= base1 + f1_88;
        result.lane2 <= '0;            // unused in 8x8
        result.lane3 <= '0;
      end else begin
        result.lane0 <= add_lane18(base0, f0_18);
        result.lane1 <= add_lane18(base1, f1_18);
        result.lane2 <= add_lane18(base2, f2_18);
        result.lane3 <= add_lane18(base3, f3_18);
      end
    end
  end

  // packing must not switch in the middle of a job
  a_mode_stable : assert property (@(posedge clk) disable iff (reset)
    en && !clear |-> mode == result.mode);

endmodule

// File: pe_row/pe_row_top.sv
`timescale 1ns/100ps
`include "pe_consts.svh"

////////////////////////////////////////////////////////////////////////////
// one pe row
// beat -> packer -> 2 stage mult -> lane accumulators -> result
////////////////////////////////////////////////////////////////////////////

module pe_row_top
  import pe_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  pe_beat_t   in_beat,
  input  logic       in_valid,
  output logic       in_ready,
  output pe_result_t out_result,
  output logic       out_valid,
  input  logic       out_ready
);

  logic      mult_en;   // mult pipeline advance
  logic      acc_en;    // product valid at accumulator
  logic      acc_clear; // first product of a job
  pe_mode_e  acc_mode;  // latched job mode
  mult_ops_t mult_ops;

  logic signed [`PE_PROD_W-1:0] mult_prod;

  pe_row_ctrl u_ctrl (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_last   (in_beat.last),
    .in_mode   (in_beat.mode),
    .in_ready  (in_ready),
    .mult_en   (mult_en),
    .acc_en    (acc_en),
    .acc_clear (acc_clear),
    .acc_mode  (acc_mode),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  operand_packer u_packer (
    .beat (in_beat),
    .ops  (mult_ops)
  );

  packed_mult u_mult (
    .clk  (clk),
    .en   (mult_en),
    .ops  (mult_ops),
    .prod (mult_prod)
  );

  lane_accumulator u_acc (
    .clk    (clk),
    .reset  (reset),
    .en     (acc_en),
    .clear  (acc_clear),
    .mode   (acc_mode),
    .prod   (mult_prod),
    .result (out_result) // held by the lane regs during HOLD
  );

endmodule

// File: verification/pe_row_tb.sv
`timescale 1ns/100ps
`include "pe_consts.svh"

module pe_row_tb
  import pe_pkg::*;
();

  // pixel patterns for a job
  typedef enum logic [1:0] {
    PAT_RANDOM  = 2'd0, // lcg pixels and weights
    PAT_NEG     = 2'd1, // negative pixels with both binary weights set
    PAT_EXTREME = 2'd2  // -128 everywhere
  } pix_pat_e;

  // one table row
  typedef struct packed {
    pe_mode_e   mode;
    logic [7:0] beats; // up to `PE_MAX_BEATS
    logic [7:0] stall; // cycles out_ready stays low with a result waiting
    pix_pat_e   pat;
  } job_t;

  logic       clk;
  logic       reset;
  pe_beat_t   in_beat;
  logic       in_valid;
  logic       in_ready;
  pe_result_t out_result;
  logic       out_valid;
  logic       out_ready;

  job_t        jobs[$];          // job table
  logic [31:0] lcg_state;
  int          cycle_count = 0;
  int          cycle_limit = 100000; // replaced once the table is built

  pe_row_top uut (
    .clk        (clk),
    .reset      (reset),
    .in_beat    (in_beat),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .out_result (out_result),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_stop($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_result(input string name, input pe_result_t got, input pe_result_t exp);
    if (got.mode !== exp.mode)
      fail_stop($sformatf("[ERROR] %s.mode: got 0x%h, expected 0x%h", name, got.mode, exp.mode));
    if (got.lane0 !== exp.lane0)
      fail_stop($sformatf("[ERROR] %s.lane0: got 0x%h, expected 0x%h", name, got.lane0, exp.lane0));
    if (got.lane1 !== exp.lane1)
      fail_stop($sformatf("[ERROR] %s.lane1: got 0x%h, expected 0x%h", name, got.lane1, exp.lane1));
    if (got.lane2 !== exp.lane2)
      fail_stop($sformatf("[ERROR] %s.lane2: got 0x%h, expected 0x%h", name, got.lane2, exp.lane2));
    if (got.lane3 !== exp.lane3)
      fail_stop($sformatf("[ERROR] %s.lane3: got 0x%h, expected 0x%h", name, got.lane3, exp.lane3));
  endtask

  // 32 bit lcg with the middle bits taken
  function automatic logic [7:0] next_rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  function automatic void add_job(input pe_mode_e mode, input int beats, input int stall,
                                  input pix_pat_e pat);
    job_t job;
    job.mode  = mode;
    job.beats = beats[7:0];
    job.stall = stall[7:0];
    job.pat   = pat;
    jobs.push_back(job);
  endfunction

  function automatic pe_beat_t make_beat(input pe_mode_e mode, input pix_pat_e pat,
                                         input logic last);
    pe_beat_t   beat;
    logic [7:0] r;
    beat.mode    = mode;
    beat.pixel0  = next_rand_byte();
    beat.pixel1  = next_rand_byte();
    beat.weight0 = next_rand_byte(); // upper bits are noise in 1x8
    r            = next_rand_byte();
    beat.weight1 = r[3];             // noise in 8x8
    beat.last    = last;
    case (pat)
      PAT_NEG: begin
        beat.pixel0[7]  = 1'b1; // forces borrows in every field
        beat.pixel1[7]  = 1'b1;
        beat.weight0[0] = 1'b1;
        beat.weight1    = 1'b1;
      end
      PAT_EXTREME: begin
        beat.pixel0  = 8'h80;
        beat.pixel1  = 8'h80;
        beat.weight0 = 8'h80;
        beat.weight1 = 1'b1;
      end
      default: ;
    endcase
    return beat;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stream one job and check timing, hold and result
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_job(input job_t job);
    pe_beat_t   beats [`PE_MAX_BEATS];
    pe_result_t exp_res;
    int         sum0, sum1, sum2, sum3;
    int         n, stall, b, i;
    n     = job.beats;
    stall = job.stall;
    sum0  = 0;
    sum1  = 0;
    sum2  = 0;
    sum3  = 0;

    // beats and reference sums
    for (b = 0; b < n; b++) begin
      beats[b] = make_beat(job.mode, job.pat, b == n - 1);
      if (job.mode == MODE_88) begin
        sum0 += int'($signed(beats[b].pixel0)) * int'($signed(beats[b].weight0));
        sum1 += int'($signed(beats[b].pixel1)) * int'($signed(beats[b].weight0));
      end else begin
        if (beats[b].weight0[0]) begin
          sum0 += int'($signed(beats[b].pixel0));
          sum1 += int'($signed(beats[b].pixel1));
        end
        if (beats[b].weight1) begin
          sum2 += int'($signed(beats[b].pixel0));
          sum3 += int'($signed(beats[b].pixel1));
        end
      end
    end

    exp_res.mode = job.mode;
    if (job.mode == MODE_88) begin
      exp_res.lane0 = sum0[23:0]; // 24 bit wrap
      exp_res.lane1 = sum1[23:0];
      exp_res.lane2 = '0;
      exp_res.lane3 = '0;
    end else begin
      exp_res.lane0 = {{8{sum0[15]}}, sum0[15:0]}; // 16 bit wrap then sign extension
      exp_res.lane1 = {{8{sum1[15]}}, sum1[15:0]};
      exp_res.lane2 = {{8{sum2[15]}}, sum2[15:0]};
      exp_res.lane3 = {{8{sum3[15]}}, sum3[15:0]};
    end

    // back to back stream with no stall inside a job
    @(posedge clk);
    in_valid <= 1'b1;
    in_beat  <= beats[0];
    for (b = 0; b < n; b++) begin
      @(negedge clk);
      check_bit("in_ready", in_ready, 1'b1);
      @(posedge clk); // beat b taken here
      if (b < n - 1) begin
        in_beat <= beats[b + 1];
      end else begin
        in_valid <= 1'b0;
        in_beat  <= '0;
      end
    end

    // result due on the third edge of the drain
    repeat (3) begin
      @(negedge clk);
      check_bit("out_valid", out_valid, 1'b0);
      check_bit("in_ready", in_ready, 1'b0);
      @(posedge clk);
    end
    @(negedge clk);
    check_bit("out_valid", out_valid, 1'b1);
    check_result("out_result", out_result, exp_res);

    // stray beat offered while the result waits is never taken
    @(posedge clk);
    in_valid <= 1'b1;
    in_beat  <= make_beat(job.mode == MODE_88 ? MODE_18 : MODE_88, PAT_RANDOM, 1'b1);
    if (stall == 0) out_ready <= 1'b1;
    for (i = 0; i < stall; i++) begin
      @(negedge clk);
      check_bit("out_valid", out_valid, 1'b1);
      check_bit("in_ready", in_ready, 1'b0);
      check_result("out_result (held)", out_result, exp_res);
      @(posedge clk);
      if (i == stall - 1) out_ready <= 1'b1;
    end
    @(negedge clk);
    check_bit("out_valid", out_valid, 1'b1);
    check_bit("in_ready", in_ready, 1'b0);
    @(posedge clk); // result transfer
    out_ready <= 1'b0;
    in_valid  <= 1'b0;
    in_beat   <= '0;
    @(negedge clk);
    check_bit("out_valid", out_valid, 1'b0);
    check_bit("in_ready", in_ready, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and timeout
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit)
      fail_stop($sformatf("timeout: no end of the job table after %0d cycles", cycle_count));
  end

  initial begin
    pe_result_t zero_res;
    int         j;
    int         total;
    reset     = 1'b1;
    in_valid  = 1'b0;
    in_beat   = '0;
    out_ready = 1'b0;
    lcg_state = 32'd56;
    zero_res  = '0;

    // mode, beats, stall, pixels
    add_job(MODE_88, 1, 0, PAT_RANDOM);
    add_job(MODE_88, 4, 3, PAT_RANDOM);
    add_job(MODE_88, 64, 0, PAT_RANDOM);
    add_job(MODE_18, 1, 2, PAT_RANDOM);
    add_job(MODE_18, 8, 0, PAT_RANDOM);
    add_job(MODE_18, 64, 4, PAT_NEG);
    add_job(MODE_88, 64, 6, PAT_EXTREME);  // -128 x -128 for 64 beats
    add_job(MODE_18, 16, 0, PAT_RANDOM);   // modes alternate from here
    add_job(MODE_88, 7, 1, PAT_RANDOM);
    add_job(MODE_18, 64, 0, PAT_EXTREME);
    add_job(MODE_88, 3, 2, PAT_NEG);

    // beats + stalls + 10 per job plus reset and slack
    total = 10;
    for (j = 0; j < jobs.size(); j++)
      total += int'(jobs[j].beats) + int'(jobs[j].stall) + 10;
    cycle_limit = total;

    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_bit("out_valid", out_valid, 1'b0);
    check_bit("in_ready", in_ready, 1'b1);
    check_result("out_result", out_result, zero_res);

    for (j = 0; j < jobs.size(); j++) begin
      $display("job %0d: mode %s, %0d beats, stall %0d",
               j, jobs[j].mode.name(), jobs[j].beats, jobs[j].stall);
      run_job(jobs[j]);
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: src.f
+incdir+common
common/pe_pkg.sv
pe_row/pe_row_ctrl.sv
pe_row/operand_packer.sv
pe_row/packed_mult.sv
pe_row/lane_accumulator.sv
pe_row/pe_row_top.sv
verification/pe_row_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the pe row testbench with verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module pe_row_tb \
  -f src.f -o pe_row_sim > build.log 2>&1 || { cat build.log; echo "BUILD FAILED"; exit 1; }

./obj_dir/pe_row_sim > sim.log 2>&1 || echo "simulator returned a failing status"
cat sim.log

grep -q "Finished with errors" sim.log && { echo "SIMULATION FAILED"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "SIMULATION FAILED, no pass line"; exit 1; }
echo "SIMULATION PASSED"
